// ==== testbench/alu_cases.txt ====
# Columns: instruction word (hex), write expected (0/1), rd (decimal), data (hex),
# idle cycles before the instruction (-1 draws 0..3 from the LFSR); rest is a note
# Load operands
00500093 1 1  00000005 -1  addi x1, x0, 5
FFD00113 1 2  FFFFFFFD -1  addi x2, x0, -3
7FF00193 1 3  000007FF -1  addi x3, x0, 2047
80000213 1 4  FFFFF800 -1  addi x4, x0, -2048
# Register-register
002082B3 1 5  00000002 -1  add x5, x1, x2
40208333 1 6  00000008 -1  sub x6, x1, x2
401003B3 1 7  FFFFFFFB -1  sub x7, x0, x1 wraps
00112433 1 8  00000001 -1  slt x8, x2, x1
001134B3 1 9  00000000 -1  sltu x9, x2, x1
0020C533 1 10 FFFFFFF8 -1  xor x10, x1, x2
001155B3 1 11 07FFFFFF -1  srl x11, x2, x1
40115633 1 12 FFFFFFFF -1  sra x12, x2, x1
0041E6B3 1 13 FFFFFFFF -1  or x13, x3, x4
00317733 1 14 000007FD -1  and x14, x2, x3
001097B3 1 15 000000A0 -1  sll x15, x1, x1
# Register-immediate
FFE12813 1 16 00000001 -1  slti x16, x2, -2
FFF0B893 1 17 00000001 -1  sltiu x17, x1, -1
FFF1C913 1 18 FFFFF800 -1  xori x18, x3, -1
0F00E993 1 19 000000F5 -1  ori x19, x1, 0xf0
0FF17A13 1 20 000000FD -1  andi x20, x2, 0xff
01C09A93 1 21 50000000 -1  slli x21, x1, 28
00425B13 1 22 0FFFFF80 -1  srli x22, x4, 4
40425B93 1 23 FFFFFF80 -1  srai x23, x4, 4
# Forwarding, then the same chain with long gaps
00108C13 1 24 00000006 -1  addi x24, x1, 1
018C0CB3 1 25 0000000C 0   add x25, x24, x24 from EX
418C8D33 1 26 00000006 0   sub x26, x25, x24 from EX and WB
064D0D93 1 27 0000006A 1   addi x27, x26, 100 from WB
01ADCE33 1 28 0000006C 1   xor x28, x27, x26 from WB
018C0EB3 1 29 0000000C 5   add x29, x24, x24
418E8F33 1 30 00000006 5   sub x30, x29, x24
# No write for x0 or unsupported encodings
00708013 0 0  00000000 -1  addi x0, x1, 7
00100FB3 1 31 00000005 0   add x31, x0, x1
02108FB3 0 31 00000000 0   mul x31, x1, x1 unsupported
12345FB7 0 31 00000000 0   lui x31 unsupported
40109F93 0 31 00000000 0   slli x31 with bad funct7
000F82B3 1 5  00000005 0   add x5, x31, x0

// ==== vlog.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/register_file.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/core_top.sv
testbench/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run tb_core with Verilator, the simulation log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_core -o tb_core \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_core > sim.log 2>&1 ; cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

// ==== testbench/tb_core.sv ====
/* Testbench for core_top: drives instruction words from the case file with random gaps
   and checks every write-back event in order against the expected queue. */

module tb_core import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // One line of the case file
  typedef struct packed {
    logic [31:0] instr;
    logic        we;
    rf_addr_t    rd;
    rf_data_t    data;
    logic        rand_gap;
    logic [3:0]  gap;
  } case_t;

  // Expected write, tagged with its issue cycle
  typedef struct packed {
    int       issue;
    rf_addr_t rd;
    rf_data_t data;
  } exp_t;

  logic        clk_i;
  logic        rst_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        wb_valid_o;
  rf_addr_t    wb_rd_o;
  rf_data_t    wb_wdata_o;

  case_t       cases[$];
  exp_t        exp_q[$];
  int          cycle_cnt = 0;
  logic [31:0] lfsr_state;

  core_top dut_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_wdata_o    (wb_wdata_o)
  );

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Cycle count, read only away from the rising edge
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped after the first failure");
  endtask

  task automatic check(string name, logic [31:0] exp_v, logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      end_with_failure();
    end
  endtask

  // Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      val = (val << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_cases();
    int          fd;
    string       line;
    logic [31:0] word;
    logic [31:0] data_v;
    int          we_v;
    int          rd_v;
    int          gap_v;
    case_t       c;
    fd = $fopen("testbench/alu_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file testbench/alu_cases.txt");
      end_with_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comments and blank lines
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%h %d %d %h %d", word, we_v, rd_v, data_v, gap_v) != 5) begin
          $display("Malformed line in the case file: %s", line);
          end_with_failure();
        end else begin
          c.instr    = word;
          c.we       = (we_v != 0);
          c.rd       = rf_addr_t'(rd_v);
          c.data     = data_v;
          c.rand_gap = (gap_v < 0);
          c.gap      = gap_v[3:0];
          cases.push_back(c);
        end
      end
      $fclose(fd);
    end
  endtask

  // Inputs change 1 ns after the edge
  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      instr_valid_i = 1'b0;
    end
  endtask

  task automatic issue(case_t c);
    exp_t e;
    @(posedge clk_i);
    #1;
    instr_valid_i = 1'b1;
    instr_i       = c.instr;
    if (c.we) begin
      e.issue = cycle_cnt;
      e.rd    = c.rd;
      e.data  = c.data;
      exp_q.push_back(e);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Write-back monitor
  //////////////////////////////////////////////////////////////////////

  // Sampled mid cycle, well clear of the rising edge
  always @(negedge clk_i) begin
    exp_t head;
    if (wb_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected register write to x%0d at %0t", wb_rd_o, $time);
        end_with_failure();
      end else begin
        head = exp_q.pop_front();
        check("wb latency", 32'd2, 32'(cycle_cnt - head.issue));
        check("wb_rd_o", 32'(head.rd), 32'(wb_rd_o));
        check("wb_wdata_o", head.data, wb_wdata_o);
      end
    end else if (exp_q.size() != 0 && (cycle_cnt - exp_q[0].issue) > 2) begin
      $display("Missing register write to x%0d issued in cycle %0d", exp_q[0].rd,
               exp_q[0].issue);
      end_with_failure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int gap;
    int wait_cycles;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lfsr_state    = 32'h7186b4b6;
    load_cases();
    if (cases.size() == 0) begin
      $display("The case file holds no cases");
      end_with_failure();
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Quiet stretch before the first instruction
    idle(4);
    foreach (cases[n]) begin
      if (cases[n].rand_gap) begin
        draw_bits(2, gap);
      end else begin
        gap = int'(cases[n].gap);
      end
      idle(gap);
      issue(cases[n]);
    end
    idle(1);
    // Drain with its own timeout
    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 16) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    // Extra cycles catch late or stray writes
    idle(8);
    if (exp_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("Drain timed out with %0d writes still outstanding", exp_q.size());
      end_with_failure();
    end
  end

endmodule

// ==== hdl/core_top.sv ====
/* Top of the integer pipeline: decode, execute and register file.
   Takes strobed instruction words and reports each register write. */

module core_top import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic        wb_valid_o,
  output rf_addr_t    wb_rd_o,
  output rf_data_t    wb_wdata_o
);

  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  rf_data_t    ex_result;
  rf_addr_t    rf_raddr_a;
  rf_addr_t    rf_raddr_b;
  rf_data_t    rf_rdata_a;
  rf_data_t    rf_rdata_b;

  id_stage id_stage_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .ex_result_i   (ex_result),
    .wb_i          (ex_wb_pipe),
    .id_ex_o       (id_ex_pipe)
  );

  ex_stage ex_stage_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .id_ex_i     (id_ex_pipe),
    .ex_result_o (ex_result),
    .ex_wb_o     (ex_wb_pipe)
  );

  // Write port fed straight from EX/WB
  register_file register_file_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wb_i      (ex_wb_pipe)
  );

  // Write-back port mirrors the register file write
  assign wb_valid_o = ex_wb_pipe.valid;
  assign wb_rd_o    = ex_wb_pipe.rd;
  assign wb_wdata_o = ex_wb_pipe.wdata;

endmodule

// ==== hdl/ex_stage.sv ====
/* Execute stage: integer ALU plus the EX/WB register that drives write-back.
   The live ALU result also goes back to decode for forwarding. */

`include "core_cfg.svh"

module ex_stage import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  id_ex_pipe_t id_ex_i,
  output rf_data_t    ex_result_o,
  output ex_wb_pipe_t ex_wb_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  rf_data_t   alu_result;

  // Shifts look at the low 5 bits only
  assign shamt = id_ex_i.operand_b[4:0];

  assign lt_signed   = $signed(id_ex_i.operand_a) < $signed(id_ex_i.operand_b);
  assign lt_unsigned = id_ex_i.operand_a < id_ex_i.operand_b;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:  alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:  alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_SLL:  alu_result = id_ex_i.operand_a << shamt;
      ALU_SLT:  alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_SRL:  alu_result = id_ex_i.operand_a >> shamt;
      // Sign bit fills from the left
      ALU_SRA:  alu_result = rf_data_t'($signed(id_ex_i.operand_a) >>> shamt);
      ALU_OR:   alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_AND:  alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      default:  alu_result = '0;
    endcase
  end

  // Forwarding path into decode
  assign ex_result_o = alu_result;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  // Only instructions that actually write a register move on
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_wb_o.valid <= 1'b0;
    end else begin
      ex_wb_o.valid <= id_ex_i.valid && id_ex_i.rf_we;
      if (id_ex_i.valid && id_ex_i.rf_we) begin
        ex_wb_o.rd    <= id_ex_i.rd;
        ex_wb_o.wdata <= alu_result;
      end
    end
  end

endmodule

// ==== hdl/id_stage.sv ====
/* Decode stage: ALU op and immediate decode, operand forwarding from EX and WB,
   and the ID/EX pipeline register feeding the execute stage. */

`include "core_cfg.svh"

module id_stage import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  input  instr_u      instr_i,
  output rf_addr_t    rf_raddr_a_o,
  output rf_addr_t    rf_raddr_b_o,
  input  rf_data_t    rf_rdata_a_i,
  input  rf_data_t    rf_rdata_b_i,
  input  rf_data_t    ex_result_i,
  input  ex_wb_pipe_t wb_i,
  output id_ex_pipe_t id_ex_o
);

  alu_op_e  alu_op_dec;
  logic     legal;
  logic     use_imm;
  logic     rf_we_dec;
  rf_data_t imm;
  rf_data_t operand_a;
  rf_data_t operand_b;

  // Shared funct3 table for OP and OP-IMM
  function automatic alu_op_e base_op(logic [2:0] funct3);
    case (funct3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Youngest producer wins: EX, then WB, then register file
  function automatic rf_data_t fwd_operand(rf_addr_t rs, rf_data_t rf_rdata);
    if (rs == '0) begin
      return '0;
    end else if (id_ex_o.valid && id_ex_o.rf_we && (id_ex_o.rd == rs)) begin
      return ex_result_i;
    end else if (wb_i.valid && (wb_i.rd == rs)) begin
      return wb_i.wdata;
    end
    return rf_rdata;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op_dec = base_op(instr_i.r.funct3);
    legal      = 1'b0;
    use_imm    = 1'b0;
    // Shift immediates carry only the 5-bit amount
    if (instr_i.i.funct3[1:0] == 2'b01) begin
      imm = {{(`CORE_XLEN-5){1'b0}}, instr_i.i.imm12[4:0]};
    end else begin
      imm = {{(`CORE_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
    end
    case (instr_i.r.opcode)
      OPCODE_OP: begin
        if (instr_i.r.funct7 == 7'b0000000) begin
          legal = 1'b1;
        end else if (instr_i.r.funct7 == 7'b0100000) begin
          // Only SUB and SRA use the alternate encoding
          if (instr_i.r.funct3 == 3'b000) begin
            legal      = 1'b1;
            alu_op_dec = ALU_SUB;
          end else if (instr_i.r.funct3 == 3'b101) begin
            legal      = 1'b1;
            alu_op_dec = ALU_SRA;
          end
        end
      end
      OPCODE_OP_IMM: begin
        use_imm = 1'b1;
        case (instr_i.i.funct3)
          3'b001:  legal = (instr_i.i.imm12[11:5] == 7'b0000000);
          3'b101: begin
            legal = (instr_i.i.imm12[11:5] == 7'b0000000) ||
                    (instr_i.i.imm12[11:5] == 7'b0100000);
            if (instr_i.i.imm12[10]) begin
              alu_op_dec = ALU_SRA;
            end
          end
          default: legal = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  // No write for x0 targets or unknown encodings
  assign rf_we_dec = legal && (instr_i.r.rd != '0);

  //////////////////////////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////////////////////////

  // rs2 field is immediate bits for OP-IMM, read is harmless
  assign rf_raddr_a_o = instr_i.r.rs1;
  assign rf_raddr_b_o = instr_i.r.rs2;

  // Forwarding picks up the EX and WB state read inside the function
  always_comb begin
    operand_a = fwd_operand(instr_i.r.rs1, rf_rdata_a_i);
    operand_b = use_imm ? imm : fwd_operand(instr_i.r.rs2, rf_rdata_b_i);
  end

  // ID/EX register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_ex_o.valid <= 1'b0;
      id_ex_o.rf_we <= 1'b0;
    end else begin
      id_ex_o.valid <= instr_valid_i;
      id_ex_o.rf_we <= instr_valid_i && rf_we_dec;
      if (instr_valid_i) begin
        id_ex_o.rd        <= instr_i.r.rd;
        id_ex_o.alu_op    <= alu_op_dec;
        id_ex_o.operand_a <= operand_a;
        id_ex_o.operand_b <= operand_b;
      end
    end
  end

endmodule

// ==== hdl/register_file.sv ====
/* Integer register file, two async read ports and one write port.
   Written from the EX/WB register; x0 always reads zero. */

`include "core_cfg.svh"

module register_file import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  rf_addr_t    raddr_a_i,
  input  rf_addr_t    raddr_b_i,
  output rf_data_t    rdata_a_o,
  output rf_data_t    rdata_b_o,
  input  ex_wb_pipe_t wb_i
);

  rf_data_t mem [`CORE_NUM_REGS];

  // Whole array cleared on reset, x0 never written afterwards
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (wb_i.valid && (wb_i.rd != '0)) begin
      mem[wb_i.rd] <= wb_i.wdata;
    end
  end

  // Async reads, x0 forced to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem[raddr_b_i];

endmodule

// ==== hdl/core_pkg.sv ====
/* Types shared by the decode, execute and register file blocks.
   Modules pull these in with a wildcard import. */

`include "core_cfg.svh"

package core_pkg;

  typedef logic [`CORE_REG_AW-1:0] rf_addr_t;
  typedef logic [`CORE_XLEN-1:0]   rf_data_t;

  // Major opcodes handled here
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OP_IMM = 7'h13;

  //////////////////////////////////////////////////////////////////////
  // Instruction views
  //////////////////////////////////////////////////////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  // Register-immediate layout, imm12 overlays funct7 and rs2
  typedef struct packed {
    logic [11:0] imm12;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     valid;
    logic     rf_we;
    rf_addr_t rd;
    alu_op_e  alu_op;
    rf_data_t operand_a;
    rf_data_t operand_b;
  } id_ex_pipe_t;

  // Valid here means a register write takes place
  typedef struct packed {
    logic     valid;
    rf_addr_t rd;
    rf_data_t wdata;
  } ex_wb_pipe_t;

endpackage

// ==== hdl/core_cfg.svh ====
/* Width and size settings for the integer pipeline.
   Included by the package and by any module that needs them. */

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path width, one RV32 word
`define CORE_XLEN 32

// Architectural registers, x0 included
`define CORE_NUM_REGS 32

// Index width for the register file
`define CORE_REG_AW 5

`endif
